/* rtl/rvj1_defines.sv */
package rvj1_defines;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////
  localparam int XLEN  = 32;
  localparam int RALEN = 5;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_OR  = 4'h3,
    ALU_XOR = 4'h4,
    ALU_SLT = 4'h5,
    ALU_SLL = 4'h6,
    ALU_SRL = 4'h7
  } alu_op_e;

  // LSU commands, bit 3 marks a write
  typedef enum logic [3:0] {
    LSU_NONE       = 4'b0000,
    LSU_LOAD_WORD  = 4'b0010,
    LSU_STORE_WORD = 4'b1010
  } lsu_ctrl_e;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // Decoded instruction as handed to the issue stage
  typedef struct packed {
    logic [RALEN-1:0] rf_addr_a;
    logic [RALEN-1:0] rf_addr_b;
    logic [RALEN-1:0] rd;
    logic             rpa_or_pc;   // Operand A is zero, not rs1
    logic             rpb_or_imm;  // Operand B is the immediate
    logic [XLEN-1:0]  imm;
    alu_op_e          alu_op;
    lsu_ctrl_e        lsu_cmd;
    logic             we;          // Writes a register
  } issue_s;

  // Register writeback
  typedef struct packed {
    logic             valid;
    logic [RALEN-1:0] rd;
    logic [XLEN-1:0]  data;
  } wb_s;

endpackage

/* rtl/rvj1_decoder.sv */
`timescale 1ns/1ns

module rvj1_decoder (
  input  logic [rvj1_defines::XLEN-1:0] instr_i,
  output rvj1_defines::issue_s          issue_o,
  output logic                          lsu_ctrl_valid_o
);
  logic [2:0]                    funct3;
  logic [rvj1_defines::XLEN-1:0] imm_i_type;
  logic [rvj1_defines::XLEN-1:0] imm_s_type;
  logic [rvj1_defines::XLEN-1:0] imm_u_type;
  rvj1_defines::alu_op_e         alu_op;
  logic                          alu_op_ok;

  assign funct3 = instr_i[14:12];

  // Sign extended immediates
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  //////////////////////////////////////////////////////////////////////
  // ALU operation from funct3, shared by OP and OP-IMM
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    alu_op    = rvj1_defines::ALU_ADD;
    alu_op_ok = 1'b1;
    case (funct3)
      // SUB only exists in register form
      3'b000: begin
        if (instr_i[6:0] == rvj1_defines::OPC_OP && instr_i[30]) begin
          alu_op = rvj1_defines::ALU_SUB;
        end
      end
      3'b001:  alu_op = rvj1_defines::ALU_SLL;
      3'b010:  alu_op = rvj1_defines::ALU_SLT;
      3'b100:  alu_op = rvj1_defines::ALU_XOR;
      3'b101:  alu_op = rvj1_defines::ALU_SRL;
      3'b110:  alu_op = rvj1_defines::ALU_OR;
      3'b111:  alu_op = rvj1_defines::ALU_AND;
      // SLTU not supported
      default: alu_op_ok = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    // Default is a no-op that writes nothing
    issue_o         = '0;
    issue_o.alu_op  = rvj1_defines::ALU_ADD;
    issue_o.lsu_cmd = rvj1_defines::LSU_NONE;
    case (instr_i[6:0])
      rvj1_defines::OPC_OP: begin
        issue_o.rf_addr_a = instr_i[19:15];
        issue_o.rf_addr_b = instr_i[24:20];
        issue_o.rd        = instr_i[11:7];
        issue_o.alu_op    = alu_op;
        issue_o.we        = alu_op_ok;
      end
      rvj1_defines::OPC_OP_IMM: begin
        issue_o.rf_addr_a  = instr_i[19:15];
        issue_o.rpb_or_imm = 1'b1;
        issue_o.imm        = imm_i_type;
        issue_o.rd         = instr_i[11:7];
        issue_o.alu_op     = alu_op;
        issue_o.we         = alu_op_ok;
      end
      // x0 plus upper immediate
      rvj1_defines::OPC_LUI: begin
        issue_o.rpa_or_pc  = 1'b1;
        issue_o.rpb_or_imm = 1'b1;
        issue_o.imm        = imm_u_type;
        issue_o.rd         = instr_i[11:7];
        issue_o.we         = 1'b1;
      end
      // Word loads only
      rvj1_defines::OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          issue_o.rf_addr_a  = instr_i[19:15];
          issue_o.rpb_or_imm = 1'b1;
          issue_o.imm        = imm_i_type;
          issue_o.rd         = instr_i[11:7];
          issue_o.lsu_cmd    = rvj1_defines::LSU_LOAD_WORD;
          issue_o.we         = 1'b1;
        end
      end
      // Base on port A, data on port B
      rvj1_defines::OPC_STORE: begin
        if (funct3 == 3'b010) begin
          issue_o.rf_addr_a  = instr_i[19:15];
          issue_o.rf_addr_b  = instr_i[24:20];
          issue_o.rpb_or_imm = 1'b1;
          issue_o.imm        = imm_s_type;
          issue_o.lsu_cmd    = rvj1_defines::LSU_STORE_WORD;
        end
      end
      default: ;
    endcase
  end

  assign lsu_ctrl_valid_o = (issue_o.lsu_cmd != rvj1_defines::LSU_NONE);

endmodule

/* rtl/rvj1_regfile.sv */
`timescale 1ns/1ns

module rvj1_regfile (
  input  logic                           clk_i,
  input  logic                           rstn_i,
  input  logic [rvj1_defines::RALEN-1:0] raddr_a_i,
  input  logic [rvj1_defines::RALEN-1:0] raddr_b_i,
  output logic [rvj1_defines::XLEN-1:0]  rdata_a_o,
  output logic [rvj1_defines::XLEN-1:0]  rdata_b_o,
  input  rvj1_defines::wb_s              wb_i
);
  // x0 has no storage
  logic [rvj1_defines::XLEN-1:0] regs [1:31];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // Combinational, x0 reads zero
  always_comb begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    if (raddr_a_i != '0) begin
      rdata_a_o = regs[raddr_a_i];
    end
    if (raddr_b_i != '0) begin
      rdata_b_o = regs[raddr_b_i];
    end
  end

endmodule

/* rtl/rvj1_alu.sv */
`timescale 1ns/1ns

module rvj1_alu (
  input  logic                           clk_i,
  input  logic                           rstn_i,
  input  rvj1_defines::issue_s           issue_i,
  input  logic                           issue_valid_i,
  input  logic [rvj1_defines::XLEN-1:0]  op_a_i,
  input  logic [rvj1_defines::XLEN-1:0]  op_b_i,
  output logic [rvj1_defines::RALEN-1:0] alu_regdest_r_o,
  output rvj1_defines::wb_s              wb_o
);
  logic [rvj1_defines::XLEN-1:0] op_a;
  logic [rvj1_defines::XLEN-1:0] op_b;
  logic [rvj1_defines::XLEN-1:0] result;
  logic [rvj1_defines::XLEN-1:0] result_r;
  logic                          alu_wr;
  logic                          wb_valid_r;

  // Operand select
  assign op_a = issue_i.rpa_or_pc  ? '0          : op_a_i;
  assign op_b = issue_i.rpb_or_imm ? issue_i.imm : op_b_i;

  always_comb begin
    case (issue_i.alu_op)
      rvj1_defines::ALU_SUB: result = op_a - op_b;
      rvj1_defines::ALU_AND: result = op_a & op_b;
      rvj1_defines::ALU_OR:  result = op_a | op_b;
      rvj1_defines::ALU_XOR: result = op_a ^ op_b;
      rvj1_defines::ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
      // Shift amount is the low five bits
      rvj1_defines::ALU_SLL: result = op_a << op_b[4:0];
      rvj1_defines::ALU_SRL: result = op_a >> op_b[4:0];
      default:               result = op_a + op_b;
    endcase
  end

  // Only issued register writes that bypass the LSU
  assign alu_wr = issue_valid_i && issue_i.we &&
                  (issue_i.lsu_cmd == rvj1_defines::LSU_NONE);

  //////////////////////////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////////////////////////

  // Destination falls back to x0 when idle
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_valid_r      <= 1'b0;
      alu_regdest_r_o <= '0;
    end else begin
      wb_valid_r      <= alu_wr;
      alu_regdest_r_o <= alu_wr ? issue_i.rd : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_wr) begin
      result_r <= result;
    end
  end

  assign wb_o.valid = wb_valid_r;
  assign wb_o.rd    = alu_regdest_r_o;
  assign wb_o.data  = result_r;

endmodule

/* rtl/rvj1_lsu.sv */
`timescale 1ns/1ns

module rvj1_lsu (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  input  rvj1_defines::issue_s          issue_i,
  input  logic                          issue_valid_i,
  input  logic [rvj1_defines::XLEN-1:0] base_i,
  input  logic [rvj1_defines::XLEN-1:0] store_data_i,
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [rvj1_defines::XLEN-1:0] mem_addr_o,
  output logic [rvj1_defines::XLEN-1:0] mem_wdata_o,
  input  logic                          mem_rvalid_i,
  input  logic [rvj1_defines::XLEN-1:0] mem_rdata_i,
  output logic                          lsu_ready_o,
  output rvj1_defines::wb_s             wb_o
);
  logic                           mem_cmd;
  logic                           pending_r;
  logic [rvj1_defines::RALEN-1:0] rd_r;

  assign mem_cmd = issue_valid_i && (issue_i.lsu_cmd != rvj1_defines::LSU_NONE);

  //////////////////////////////////////////////////////////////////////
  // Request pulse and load tracking
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mem_req_o <= 1'b0;
      mem_we_o  <= 1'b0;
      pending_r <= 1'b0;
    end else begin
      mem_req_o <= mem_cmd;
      mem_we_o  <= mem_cmd && issue_i.lsu_cmd[3];
      // Load waits for its data
      if (mem_cmd && !issue_i.lsu_cmd[3]) begin
        pending_r <= 1'b1;
      end else if (mem_rvalid_i) begin
        pending_r <= 1'b0;
      end
    end
  end

  // Address, store data and load destination
  always_ff @(posedge clk_i) begin
    if (mem_cmd) begin
      mem_addr_o  <= base_i + issue_i.imm;
      mem_wdata_o <= store_data_i;
      rd_r        <= issue_i.rd;
    end
  end

  // Load data goes straight to writeback
  assign lsu_ready_o = pending_r && mem_rvalid_i;
  assign wb_o.valid  = lsu_ready_o;
  assign wb_o.rd     = rd_r;
  assign wb_o.data   = mem_rdata_i;

  // Controller stall must keep commands away from an open load
  a_no_cmd_in_load: assert property (@(posedge clk_i) disable iff (!rstn_i)
    pending_r |-> !mem_cmd);

  // Memory returns data only for a load request
  a_rvalid_pending: assert property (@(posedge clk_i) disable iff (!rstn_i)
    mem_rvalid_i |-> pending_r);

endmodule

/* rtl/rvj1_ctrl.sv */
`timescale 1ns/1ns

module rvj1_ctrl #(
  parameter bit [31:0] BOOT_ADDR = 32'h8000_0000
) (
  input  logic                           clk_i,
  input  logic                           rstn_i,

  input  logic [rvj1_defines::RALEN-1:0] rf_addr_a_i,
  input  logic [rvj1_defines::RALEN-1:0] rf_addr_b_i,
  input  logic                           rpa_or_pc_i,
  input  logic                           rpb_or_imm_i,
  input  logic [rvj1_defines::RALEN-1:0] alu_regdest_r_i,
  input  rvj1_defines::lsu_ctrl_e        lsu_cmd_i,
  input  logic                           lsu_ctrl_valid_i,
  input  logic                           lsu_ready_i,

  input  logic                           instr_issued_i,
  output logic                           stall_o,
  output logic [rvj1_defines::XLEN-1:0]  program_counter_o,

  output logic                           jmp_addr_valid_o,
  output logic [rvj1_defines::XLEN-1:0]  jmp_addr_o
);
  typedef enum logic [2:0] {
    eRESET,
    eBOOT0,
    eBOOT1,
    eRUN,
    eLOAD  // Waiting on load data
  } rvj1_fsm_e;

  rvj1_fsm_e state;
  rvj1_fsm_e state_next;

  logic rf_a_hazard;
  logic rf_b_hazard;
  logic lsu_b_hazard;
  logic load;
  logic loaded;

  //////////////////////////////////////////////////////////////////////
  // Hazard detection
  //////////////////////////////////////////////////////////////////////

  // Source matches the pending ALU destination
  assign rf_a_hazard = (alu_regdest_r_i == rf_addr_a_i) && !rpa_or_pc_i &&
                       (rf_addr_a_i != '0);
  assign rf_b_hazard = (alu_regdest_r_i == rf_addr_b_i) && !rpb_or_imm_i &&
                       (rf_addr_b_i != '0);

  // Store data rides port B beside the immediate
  assign lsu_b_hazard = (alu_regdest_r_i == rf_addr_b_i) && lsu_ctrl_valid_i &&
                        lsu_cmd_i[3] && (rf_addr_b_i != '0);

  assign stall_o = rf_a_hazard || rf_b_hazard || lsu_b_hazard || (state == eLOAD);

  // Boot jump strobe
  assign jmp_addr_valid_o = (state == eBOOT0);
  assign jmp_addr_o       = BOOT_ADDR;

  //////////////////////////////////////////////////////////////////////
  // Program counter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      program_counter_o <= BOOT_ADDR;
    end else if (instr_issued_i) begin
      program_counter_o <= program_counter_o + 32'd4;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////
  assign load   = instr_issued_i && lsu_ctrl_valid_i && !lsu_cmd_i[3];
  assign loaded = (state == eLOAD) && lsu_ready_i;

  always_comb begin
    state_next = state;
    case (state)
      eRESET:  state_next = eBOOT0;
      eBOOT0:  state_next = eBOOT1;
      eBOOT1:  state_next = eRUN;
      default: ;
    endcase
    // Load entry and exit win over boot stepping
    if (load) begin
      state_next = eLOAD;
    end
    if (loaded) begin
      state_next = eRUN;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state <= eRESET;
    end else begin
      state <= state_next;
    end
  end

  // Top level issue strobe honors the stall
  a_no_issue_in_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_issued_i |-> !stall_o);

  // Single boot jump
  a_jmp_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    jmp_addr_valid_o |=> !jmp_addr_valid_o);

endmodule

/* rtl/rvj1_core_top.sv */
`timescale 1ns/1ns

module rvj1_core_top #(
  parameter bit [31:0] BOOT_ADDR = 32'h8000_0000
) (
  input  logic                          clk_i,
  input  logic                          rstn_i,

  // Instruction source
  input  logic                          instr_valid_i,
  input  logic [rvj1_defines::XLEN-1:0] instr_i,
  output logic                          stall_o,
  output logic [rvj1_defines::XLEN-1:0] pc_o,

  // Boot jump
  output logic                          boot_jmp_valid_o,
  output logic [rvj1_defines::XLEN-1:0] boot_jmp_addr_o,

  // Data memory
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [rvj1_defines::XLEN-1:0] mem_addr_o,
  output logic [rvj1_defines::XLEN-1:0] mem_wdata_o,
  input  logic                          mem_rvalid_i,
  input  logic [rvj1_defines::XLEN-1:0] mem_rdata_i,

  output rvj1_defines::wb_s             wb_o
);
  rvj1_defines::issue_s           issue;
  logic                           lsu_ctrl_valid;
  logic                           instr_issued;
  logic [rvj1_defines::XLEN-1:0]  rdata_a;
  logic [rvj1_defines::XLEN-1:0]  rdata_b;
  logic [rvj1_defines::RALEN-1:0] alu_regdest_r;
  rvj1_defines::wb_s              alu_wb;
  rvj1_defines::wb_s              lsu_wb;
  logic                           lsu_ready;

  //////////////////////////////////////////////////////////////////////
  // Issue and writeback merge
  //////////////////////////////////////////////////////////////////////
  assign instr_issued = instr_valid_i && !stall_o;

  // Load data first, ALU is idle during a load
  assign wb_o = lsu_wb.valid ? lsu_wb : alu_wb;

  rvj1_decoder u_decoder (
    .instr_i          (instr_i),
    .issue_o          (issue),
    .lsu_ctrl_valid_o (lsu_ctrl_valid)
  );

  rvj1_regfile u_regfile (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .raddr_a_i (issue.rf_addr_a),
    .raddr_b_i (issue.rf_addr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .wb_i      (wb_o)
  );

  rvj1_alu u_alu (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .issue_i         (issue),
    .issue_valid_i   (instr_issued),
    .op_a_i          (rdata_a),
    .op_b_i          (rdata_b),
    .alu_regdest_r_o (alu_regdest_r),
    .wb_o            (alu_wb)
  );

  // Base from port A, store data from port B
  rvj1_lsu u_lsu (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .issue_i       (issue),
    .issue_valid_i (instr_issued),
    .base_i        (rdata_a),
    .store_data_i  (rdata_b),
    .mem_req_o     (mem_req_o),
    .mem_we_o      (mem_we_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .lsu_ready_o   (lsu_ready),
    .wb_o          (lsu_wb)
  );

  rvj1_ctrl #(
    .BOOT_ADDR (BOOT_ADDR)
  ) u_ctrl (
    .clk_i             (clk_i),
    .rstn_i            (rstn_i),
    .rf_addr_a_i       (issue.rf_addr_a),
    .rf_addr_b_i       (issue.rf_addr_b),
    .rpa_or_pc_i       (issue.rpa_or_pc),
    .rpb_or_imm_i      (issue.rpb_or_imm),
    .alu_regdest_r_i   (alu_regdest_r),
    .lsu_cmd_i         (issue.lsu_cmd),
    .lsu_ctrl_valid_i  (lsu_ctrl_valid),
    .lsu_ready_i       (lsu_ready),
    .instr_issued_i    (instr_issued),
    .stall_o           (stall_o),
    .program_counter_o (pc_o),
    .jmp_addr_valid_o  (boot_jmp_valid_o),
    .jmp_addr_o        (boot_jmp_addr_o)
  );

endmodule

/* tb/rvj1_core_tb.sv */
`timescale 1ns/1ns

module rvj1_core_tb;

  localparam bit [31:0] BOOT_ADDR   = 32'h8000_0000;
  localparam int        MAX_ENTRIES = 64;
  localparam int        COLS        = 5;

  // Entry kinds with bit 4 flagging an expected one cycle stall
  localparam bit [3:0]  K_ALU   = 4'h1;
  localparam bit [3:0]  K_STORE = 4'h2;
  localparam bit [3:0]  K_LOAD  = 4'h3;

  logic                          clk_i;
  logic                          rstn_i;
  logic                          instr_valid_i;
  logic [31:0]                   instr_i;
  logic                          stall_o;
  logic [31:0]                   pc_o;
  logic                          boot_jmp_valid_o;
  logic [31:0]                   boot_jmp_addr_o;
  logic                          mem_req_o;
  logic                          mem_we_o;
  logic [31:0]                   mem_addr_o;
  logic [31:0]                   mem_wdata_o;
  logic                          mem_rvalid_i;
  logic [31:0]                   mem_rdata_i;
  rvj1_defines::wb_s             wb;

  // Five words per entry holding kind, instruction, address, rd and value
  logic [31:0] golden [0:MAX_ENTRIES*COLS-1];

  int          num_entries;
  int          cycle_limit;
  int          cycles;
  int          boot_count;
  int          wb_count;
  int          wb_expected;
  logic [31:0] seed;

  rvj1_core_top #(
    .BOOT_ADDR (BOOT_ADDR)
  ) DUT (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .stall_o          (stall_o),
    .pc_o             (pc_o),
    .boot_jmp_valid_o (boot_jmp_valid_o),
    .boot_jmp_addr_o  (boot_jmp_addr_o),
    .mem_req_o        (mem_req_o),
    .mem_we_o         (mem_we_o),
    .mem_addr_o       (mem_addr_o),
    .mem_wdata_o      (mem_wdata_o),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rdata_i      (mem_rdata_i),
    .wb_o             (wb)
  );

  // 20 ns clock
  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Simulation ran past its cycle limit without finishing");
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // Boot strobe and writeback monitor on the rising edge
  // Counts each writeback the register file takes
  always @(posedge clk_i) begin
    if (rstn_i) begin
      if (boot_jmp_valid_o) begin
        boot_count <= boot_count + 1;
        compare("boot_jmp_addr_o", BOOT_ADDR, boot_jmp_addr_o);
      end
      if (wb.valid) begin
        wb_count <= wb_count + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // One golden entry entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic run_entry(input int idx);
    logic [31:0] kind;
    logic [31:0] addr;
    logic [31:0] rd;
    logic [31:0] value;
    int          stalls;
    int          lat;
    kind  = golden[idx*COLS];
    addr  = golden[idx*COLS+2];
    rd    = golden[idx*COLS+3];
    value = golden[idx*COLS+4];
    instr_valid_i = 1'b1;
    instr_i       = golden[idx*COLS+1];
    // Let the hazard logic settle on the new word
    #1;
    stalls = 0;
    while (stall_o) begin
      stalls++;
      @(negedge clk_i);
      #1;
    end
    compare("stall_cycles", {31'b0, kind[4]}, stalls);
    @(negedge clk_i);
    case (kind[3:0])
      K_ALU: begin
        compare("wb_o.valid", 32'd1, {31'b0, wb.valid});
        compare("wb_o.rd", rd, {27'b0, wb.rd});
        compare("wb_o.data", value, wb.data);
        compare("mem_req_o", 32'd0, {31'b0, mem_req_o});
      end
      K_STORE: begin
        compare("mem_req_o", 32'd1, {31'b0, mem_req_o});
        compare("mem_we_o", 32'd1, {31'b0, mem_we_o});
        compare("mem_addr_o", addr, mem_addr_o);
        compare("mem_wdata_o", value, mem_wdata_o);
      end
      K_LOAD: begin
        compare("mem_req_o", 32'd1, {31'b0, mem_req_o});
        compare("mem_we_o", 32'd0, {31'b0, mem_we_o});
        compare("mem_addr_o", addr, mem_addr_o);
        compare("stall_o", 32'd1, {31'b0, stall_o});
      end
      default: begin
        $display("Golden entry %0d has an unknown kind %h", idx, kind);
        $display("TEST FAILED");
        $fatal(1, "bad golden entry");
      end
    endcase
    instr_valid_i = 1'b0;
    if (kind[3:0] == K_LOAD) begin
      // Latency of 1 to 4 cycles after the request
      seed = lcg_next(seed);
      lat  = int'(seed[17:16]) + 1;
      repeat (lat) begin
        @(negedge clk_i);
        compare("stall_o", 32'd1, {31'b0, stall_o});
        // Request is a single cycle pulse
        compare("mem_req_o", 32'd0, {31'b0, mem_req_o});
      end
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = value;
      #1;
      compare("wb_o.valid", 32'd1, {31'b0, wb.valid});
      compare("wb_o.rd", rd, {27'b0, wb.rd});
      compare("wb_o.data", value, wb.data);
      compare("stall_o", 32'd1, {31'b0, stall_o});
      @(negedge clk_i);
      compare("stall_o", 32'd0, {31'b0, stall_o});
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = '0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk_i         = 1'b0;
    rstn_i        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    cycles        = 0;
    cycle_limit   = 1000;
    boot_count    = 0;
    wb_count      = 0;
    wb_expected   = 0;
    seed          = 32'h0001c4d0;

    $readmemh("tb/rvj1_golden.txt", golden);
    num_entries = 0;
    while (num_entries < MAX_ENTRIES && golden[num_entries*COLS] != 32'd0) begin
      if (golden[num_entries*COLS][3:0] != K_STORE) begin
        wb_expected++;
      end
      num_entries++;
    end
    cycle_limit = 30 * num_entries + 50;

    // Reset for 3 cycles
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;

    // No issue before the boot jump
    while (boot_count == 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    compare("pc_o", BOOT_ADDR, pc_o);
    compare("stall_o", 32'd0, {31'b0, stall_o});
    // Idle outputs out of reset
    compare("mem_req_o", 32'd0, {31'b0, mem_req_o});
    compare("mem_we_o", 32'd0, {31'b0, mem_we_o});
    compare("wb_o.valid", 32'd0, {31'b0, wb.valid});

    for (int i = 0; i < num_entries; i++) begin
      run_entry(i);
    end

    repeat (3) @(negedge clk_i);
    compare("pc_o", BOOT_ADDR + 32'd4 * num_entries, pc_o);
    compare("boot_count", 32'd1, boot_count);
    compare("wb_count", wb_expected, wb_count);
    $display("TEST OK");
    $finish;
  end

endmodule

/* tb/rvj1_golden.txt */
// kind instr addr rd value; kind 1 ALU, 2 SW, 3 LW, +10 expects one stall
// ALU: rd and result; SW: address and data; LW: address, rd and returned data
00000001 00500093 00000000 00000001 00000005
00000001 12300113 00000000 00000002 00000123
00000011 002081B3 00000000 00000003 00000128
00000011 40118233 00000000 00000004 00000123
00000001 ABCDE2B7 00000000 00000005 ABCDE000
00000011 0022C333 00000000 00000006 ABCDE123
00000012 0060A423 0000000D 00000000 ABCDE123
00000003 00412383 00000127 00000007 5A5A1234
00000001 0013E433 00000000 00000008 5A5A1235
00000011 001414B3 00000000 00000009 4B4246A0
00000011 0014D533 00000000 0000000A 025A1235
00000001 0012A5B3 00000000 0000000B 00000001
00000011 0035F633 00000000 0000000C 00000000
00000001 FFF00693 00000000 0000000D FFFFFFFF
00000012 FED12E23 0000011F 00000000 FFFFFFFF
00000003 0006A703 FFFFFFFF 0000000E 0BADF00D
00000001 00E707B3 00000000 0000000F 175BE01A
// End of sequence
00000000 00000000 00000000 00000000 00000000

/* all.f */
rtl/rvj1_defines.sv
rtl/rvj1_decoder.sv
rtl/rvj1_regfile.sv
rtl/rvj1_alu.sv
rtl/rvj1_lsu.sv
rtl/rvj1_ctrl.sv
rtl/rvj1_core_top.sv
tb/rvj1_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f \
  --top-module rvj1_core_tb -o rvj1_core_sim

./obj_dir/rvj1_core_sim
